// ==== build.f ====
logic/exPkg.sv
logic/idExReg.sv
logic/operandFwd.sv
logic/alu.sv
logic/exMemReg.sv
logic/execStage.sv
sim/clkGen.sv
sim/execStageTb.sv

// ==== Bender.yml ====
package:
  name: exec_stage

sources:
  # Package first, then the stage blocks and the top level
  - logic/exPkg.sv
  - logic/idExReg.sv
  - logic/operandFwd.sv
  - logic/alu.sv
  - logic/exMemReg.sv
  - logic/execStage.sv

  - target: simulation
    files:
      - sim/clkGen.sv
      - sim/execStageTb.sv

# Simulation top: execStageTb
# Design top: execStage

// ==== sim/execStageTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module execStageTb;

   localparam int periodNs    = 4;
   localparam int resetCycles = 4;
   localparam int driveDelay  = 1;
   localparam int numRandom   = 150;
   localparam int numDirected = 51;
   localparam int watchdogNs  = (resetCycles + 20 * (numDirected + numRandom)) * periodNs;

   logic         clk;
   logic         rst;
   logic         inValid;
   logic         inReady;
   exPkg::idExT  inInstr;
   exPkg::wbFwdT wbFwd;
   logic         outValid;
   logic         outReady;
   exPkg::exMemT outData;

   logic [exPkg::xlen-1:0] commitRegs [32];    // Written back results, feeds rs values
   logic [exPkg::xlen-1:0] specRegs [32];      // Program order values for expectations
   exPkg::exMemT expQ [$];
   string        nameQ [$];
   exPkg::exMemT expHead;
   string        headName;
   logic         headValid;
   logic         outFire;
   exPkg::exMemT outSnap;
   logic [31:0]  mainLfsr;
   logic [31:0]  readyLfsr;
   logic         randomReady;
   string        testName;
   int           issued;
   int           received;

   clkGen #(.periodNs(periodNs), .resetCycles(resetCycles)) clkGen_i (.clk(clk), .rst(rst));

   execStage execStage_i (
      .clk      (clk),
      .rst      (rst),
      .inValid  (inValid),
      .inReady  (inReady),
      .inInstr  (inInstr),
      .wbFwd    (wbFwd),
      .outValid (outValid),
      .outReady (outReady),
      .outData  (outData)
   );

   task automatic failRun(input string what);
      $display("%s", what);
      $display("tests failed");
      $fatal(1, "Simulation stopped on first error");
   endtask

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] takeBits(inout logic [31:0] state, input int n);
      logic [31:0] bits;
      logic        fb;
      int          i;
      bits = '0;
      for (i = 0; i < n; i++) begin
         fb    = state[31] ^ state[21] ^ state[1] ^ state[0];
         state = {state[30:0], fb};
         bits  = {bits[30:0], fb};
      end
      return bits;
   endfunction

   function automatic string describeOut(input exPkg::exMemT d);
      return $sformatf("rd=%0d wr=%b result=%h nzcv=%b", d.rd, d.regWrite, d.result, d.flags);
   endfunction

   // Expected output worked out from the ALU rules
   function automatic exPkg::exMemT expectedOut(input exPkg::idExT ins,
                                                input logic [31:0] a, input logic [31:0] b);
      exPkg::exMemT e;
      logic [31:0]  r;
      longint       wide;
      logic         c;
      logic         v;
      c = 1'b0;
      v = 1'b0;
      case (ins.aluOp)
         exPkg::aluAnd:  r = a & b;
         exPkg::aluOr:   r = a | b;
         exPkg::aluXor:  r = a ^ b;
         exPkg::aluAdd: begin
            r    = a + b;
            c    = (r < a);                    // Wrapped below an operand
            wide = longint'($signed(a)) + longint'($signed(b));
            v    = (wide != longint'($signed(r)));
         end
         exPkg::aluSub: begin
            r    = a - b;
            c    = (a < b);                    // Borrow
            wide = longint'($signed(a)) - longint'($signed(b));
            v    = (wide != longint'($signed(r)));
         end
         exPkg::aluSll:  r = a << b[4:0];
         exPkg::aluSrl:  r = a >> b[4:0];
         exPkg::aluSra:  r = $signed(a) >>> b[4:0];
         exPkg::aluSlt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         exPkg::aluSltu: r = (a < b) ? 32'd1 : 32'd0;
         default:        r = '0;
      endcase
      e.rd             = ins.rd;
      e.regWrite       = ins.regWrite;
      e.result         = r;
      e.flags.negative = r[31];
      e.flags.zero     = (r == 32'd0);
      e.flags.carry    = c;
      e.flags.overflow = v;
      return e;
   endfunction

   function automatic exPkg::idExT makeInstr(input logic [3:0] op, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2,
                                             input logic [31:0] imm, input logic useImm);
      exPkg::idExT ins;
      ins          = '0;
      ins.aluOp    = exPkg::aluOpE'(op);
      ins.rd       = rd;
      ins.rs1      = rs1;
      ins.rs2      = rs2;
      ins.imm      = imm;
      ins.useImm   = useImm;
      ins.regWrite = 1'b1;
      return ins;
   endfunction

   function automatic logic [4:0] randReg();
      return 5'(takeBits(mainLfsr, 5));
   endfunction

   // Few registers so hazards are common
   function automatic exPkg::idExT randomInstr();
      exPkg::idExT ins;
      ins          = makeInstr(4'(takeBits(mainLfsr, 4)), 5'(takeBits(mainLfsr, 3)),
                               5'(takeBits(mainLfsr, 3)), 5'(takeBits(mainLfsr, 3)),
                               takeBits(mainLfsr, 32), takeBits(mainLfsr, 1) == 1);
      ins.regWrite = (takeBits(mainLfsr, 2) != 0);
      return ins;
   endfunction

   task automatic recordIssue(input exPkg::idExT ins);
      logic [31:0]  a;
      logic [31:0]  b;
      exPkg::exMemT e;
      a = specRegs[ins.rs1];
      b = ins.useImm ? ins.imm : specRegs[ins.rs2];
      e = expectedOut(ins, a, b);
      expQ.push_back(e);
      nameQ.push_back(testName);
      if (ins.regWrite && ins.rd != 0) begin
         specRegs[ins.rd] = e.result;
      end
      issued++;
   endtask

   // Register values are reread each cycle while waiting, as decode would
   task automatic issue(input exPkg::idExT ins);
      logic taken;
      taken = 1'b0;
      while (!taken) begin
         ins.rs1Val = commitRegs[ins.rs1];
         ins.rs2Val = commitRegs[ins.rs2];
         inInstr    = ins;
         inValid    = 1'b1;
         @(negedge clk);
         taken = inReady;
         @(posedge clk);
         if (taken) begin
            recordIssue(ins);
         end
         #(driveDelay);
      end
   endtask

   task automatic idle(input int n);
      inValid = 1'b0;
      repeat (n) begin
         @(posedge clk);
         #(driveDelay);
      end
   endtask

   task automatic runOpcodes();
      logic [3:0] opList [11];
      int         i;
      opList   = '{4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8, 4'd9, 4'd15};
      testName = "opcodes";
      for (i = 0; i < 11; i++) begin
         issue(makeInstr(opList[i], randReg(), randReg(), randReg(), 32'd0, 1'b0));
         issue(makeInstr(opList[i], randReg(), randReg(), 5'd0, takeBits(mainLfsr, 32), 1'b1));
      end
   endtask

   task automatic flagCase(input logic [31:0] a, input logic [3:0] op, input logic [31:0] b);
      issue(makeInstr(4'd2, 5'd5, 5'd0, 5'd0, a, 1'b1));
      issue(makeInstr(op, 5'd6, 5'd5, 5'd0, b, 1'b1));
   endtask

   task automatic runFlags();
      testName = "flags";
      flagCase(32'hffff_ffff, 4'd2, 32'h0000_0001);   // Carry out and zero
      flagCase(32'h0000_0001, 4'd6, 32'h0000_0002);   // Borrow
      flagCase(32'h7fff_ffff, 4'd2, 32'h0000_0001);   // Positive overflow
      flagCase(32'h8000_0000, 4'd6, 32'h0000_0001);   // Negative overflow
      flagCase(32'h8000_0000, 4'd2, 32'h8000_0000);
      flagCase(32'h0000_1234, 4'd6, 32'h0000_1234);
   endtask

   task automatic runChain();
      logic [3:0] chainOps [4];
      int         i;
      chainOps = '{4'd2, 4'd3, 4'd6, 4'd1};
      testName = "forwardChain";
      issue(makeInstr(4'd2, 5'd10, 5'd0, 5'd0, takeBits(mainLfsr, 32), 1'b1));
      for (i = 0; i < 7; i++) begin
         issue(makeInstr(chainOps[i % 4], 5'(11 + i), 5'(10 + i), 5'((i == 0) ? 10 : 9 + i),
                         32'd0, 1'b0));
      end
      // Writes to x0 must never reach a reader
      issue(makeInstr(4'd2, 5'd0, 5'd0, 5'd0, 32'h5a5a_0f0f, 1'b1));
      issue(makeInstr(4'd1, 5'd20, 5'd0, 5'd0, 32'd0, 1'b0));
      issue(makeInstr(4'd2, 5'd21, 5'd0, 5'd0, 32'd0, 1'b0));
   endtask

   task automatic runWbPriority();
      testName = "wbPriority";
      issue(makeInstr(4'd2, 5'd20, 5'd0, 5'd0, takeBits(mainLfsr, 32), 1'b1));
      issue(makeInstr(4'd2, 5'd21, 5'd0, 5'd0, takeBits(mainLfsr, 32), 1'b1));
      issue(makeInstr(4'd3, 5'd22, 5'd20, 5'd21, 32'd0, 1'b0));   // r20 from writeback
      issue(makeInstr(4'd2, 5'd23, 5'd0, 5'd0, takeBits(mainLfsr, 32), 1'b1));
      issue(makeInstr(4'd2, 5'd23, 5'd0, 5'd0, takeBits(mainLfsr, 32), 1'b1));
      issue(makeInstr(4'd1, 5'd24, 5'd23, 5'd0, 32'd0, 1'b0));    // Younger r23 wins
   endtask

   task automatic runRandom();
      int i;
      testName    = "randomStress";
      randomReady = 1'b1;
      for (i = 0; i < numRandom; i++) begin
         issue(randomInstr());
         if (takeBits(mainLfsr, 2) == 0) begin
            idle(int'(takeBits(mainLfsr, 2)));
         end
      end
      idle(1);
   endtask

   always @(posedge clk) begin
      #(driveDelay);
      outReady = randomReady ? takeBits(readyLfsr, 1) == 1 : 1'b1;
   end

   // Values settle by mid cycle and hold until the next edge
   always @(negedge clk) begin
      outFire   = !rst && outValid && outReady;
      outSnap   = outData;
      headValid = (expQ.size() > 0);
      if (headValid) begin
         expHead  = expQ[0];
         headName = nameQ[0];
      end
   end

   // Writeback stage model holds the last accepted result
   always @(posedge clk) begin
      if (outFire) begin
         if (expQ.size() > 0) begin
            expQ.delete(0);
            nameQ.delete(0);
         end
         received++;
         if (outSnap.regWrite && outSnap.rd != 0) begin
            commitRegs[outSnap.rd] = outSnap.result;
         end
         #(driveDelay);
         wbFwd.regWrite = outSnap.regWrite;
         wbFwd.rd       = outSnap.rd;
         wbFwd.result   = outSnap.result;
      end
   end

   noExtra: assert property (@(posedge clk) disable iff (rst) outValid && outReady |-> headValid)
      else failRun("A result came out with no instruction outstanding");

   dataMatch: assert property (@(posedge clk) disable iff (rst)
         outValid && outReady && headValid |-> outData == expHead)
      else failRun($sformatf("[FAIL] %s: expected %s actual %s", headName,
                             describeOut(expHead), describeOut($sampled(outData))));

   stallHold: assert property (@(posedge clk) disable iff (rst)
         outValid && !outReady |=> outValid && $stable(outData))
      else failRun("Output changed or dropped while the consumer was stalling");

   initial begin
      #(watchdogNs);
      failRun($sformatf("Timeout with %0d of %0d results received", received, issued));
   end

   initial begin
      int r;
      inValid     = 1'b0;
      inInstr     = '0;
      wbFwd       = '0;
      outReady    = 1'b1;
      randomReady = 1'b0;
      issued      = 0;
      received    = 0;
      testName    = "reset";
      mainLfsr    = 32'hc836;
      readyLfsr   = 32'hc836;
      commitRegs[0] = '0;
      specRegs[0]   = '0;
      for (r = 1; r < 32; r++) begin
         commitRegs[r] = takeBits(mainLfsr, 32);
         specRegs[r]   = commitRegs[r];
      end
      @(negedge rst);
      resetState: assert (!outValid && inReady)
         else failRun("After reset outValid was high or inReady was low");
      @(posedge clk);
      #(driveDelay);
      runOpcodes();
      runFlags();
      runChain();
      runWbPriority();
      runRandom();
      while (expQ.size() != 0) begin
         @(posedge clk);
      end
      repeat (2) @(posedge clk);
      if (received == issued && issued > 0) begin
         $display("all tests passed");
         $finish;
      end else begin
         failRun($sformatf("%0d instructions issued but %0d results received", issued, received));
      end
   end

endmodule

`default_nettype wire

// ==== sim/clkGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clkGen #(
   parameter int periodNs    = 4,
   parameter int resetCycles = 4
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(periodNs / 2.0) clk = ~clk;
   end

   // Reset drops just after an edge, like the other inputs
   initial begin
      rst = 1'b1;
      repeat (resetCycles) @(posedge clk);
      #1;
      rst = 1'b0;
   end

endmodule

`default_nettype wire

// ==== logic/execStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execStage (
   input  logic         clk,
   input  logic         rst,
   input  logic         inValid,
   output logic         inReady,
   input  exPkg::idExT  inInstr,
   input  exPkg::wbFwdT wbFwd,
   output logic         outValid,
   input  logic         outReady,
   output exPkg::exMemT outData
);

   logic                   exValid;
   exPkg::idExT            exInstr;
   logic                   exAdvance;
   logic [exPkg::xlen-1:0] opA;
   logic [exPkg::xlen-1:0] opB;
   exPkg::aluOpE           aluOp;
   logic [exPkg::xlen-1:0] result;
   exPkg::aluFlagsT        flags;

   idExReg idExReg_i (
      .clk       (clk),
      .rst       (rst),
      .inValid   (inValid),
      .inReady   (inReady),
      .inInstr   (inInstr),
      .exAdvance (exAdvance),
      .exValid   (exValid),
      .exInstr   (exInstr)
   );

   // Held EX/MEM output doubles as the near forwarding source
   operandFwd operandFwd_i (
      .exInstr    (exInstr),
      .exMemHeld  (outData),
      .exMemValid (outValid),
      .wbFwd      (wbFwd),
      .opA        (opA),
      .opB        (opB),
      .aluOp      (aluOp)
   );

   alu alu_i (
      .opA    (opA),
      .opB    (opB),
      .aluOp  (aluOp),
      .result (result),
      .flags  (flags)
   );

   exMemReg exMemReg_i (
      .clk       (clk),
      .rst       (rst),
      .exValid   (exValid),
      .exInstr   (exInstr),
      .result    (result),
      .flags     (flags),
      .exAdvance (exAdvance),
      .outValid  (outValid),
      .outReady  (outReady),
      .outData   (outData)
   );

endmodule

`default_nettype wire

// ==== logic/exMemReg.sv ====
`timescale 1ns/1ps
`default_nettype none

module exMemReg (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   exValid,
   input  exPkg::idExT            exInstr,
   input  logic [exPkg::xlen-1:0] result,
   input  exPkg::aluFlagsT        flags,
   output logic                   exAdvance,
   output logic                   outValid,
   input  logic                   outReady,
   output exPkg::exMemT           outData
);

   logic canLoad;

   // Register is free when empty or its item leaves this cycle
   assign canLoad   = !outValid || outReady;
   assign exAdvance = exValid && canLoad;

   always_ff @(posedge clk) begin
      if (rst) begin
         outValid <= 1'b0;
      end else if (canLoad) begin
         outValid <= exValid;
      end
   end

   always_ff @(posedge clk) begin
      if (exAdvance) begin
         outData.rd       <= exInstr.rd;
         outData.regWrite <= exInstr.regWrite;
         outData.result   <= result;
         outData.flags    <= flags;
      end
   end

   // Back-pressure keeps the output item in place
   property validHeld;
      @(posedge clk) disable iff (rst)
         outValid && !outReady |=> outValid;
   endproperty

   property dataHeld;
      @(posedge clk) disable iff (rst)
         outValid && !outReady |=> $stable(outData);
   endproperty

   outValidHold: assert property (validHeld)
      else $error("exMemReg: outValid dropped under back-pressure");

   outDataHold: assert property (dataHeld)
      else $error("exMemReg: outData changed under back-pressure");

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
   input  logic [exPkg::xlen-1:0] opA,
   input  logic [exPkg::xlen-1:0] opB,
   input  exPkg::aluOpE           aluOp,
   output logic [exPkg::xlen-1:0] result,
   output exPkg::aluFlagsT        flags
);

   logic [exPkg::xlen:0]   sum;               // Extra bit keeps carry or borrow
   logic [4:0]             shamt;
   logic                   isAdd;
   logic                   isSub;
   logic                   addOvf;
   logic                   subOvf;

   assign shamt = opB[4:0];                   // RV32I uses five shift bits
   assign isAdd = (aluOp == exPkg::aluAdd);
   assign isSub = (aluOp == exPkg::aluSub);

   // One adder serves both ADD and SUB
   always_comb begin
      if (isSub) begin
         sum = {1'b0, opA} - {1'b0, opB};
      end else begin
         sum = {1'b0, opA} + {1'b0, opB};
      end
   end

   always_comb begin
      case (aluOp)
         exPkg::aluAnd:  result = opA & opB;
         exPkg::aluOr:   result = opA | opB;
         exPkg::aluAdd:  result = sum[exPkg::xlen-1:0];
         exPkg::aluXor:  result = opA ^ opB;
         exPkg::aluSll:  result = opA << shamt;
         exPkg::aluSrl:  result = opA >> shamt;
         exPkg::aluSub:  result = sum[exPkg::xlen-1:0];
         exPkg::aluSra:  result = $signed(opA) >>> shamt;
         exPkg::aluSlt: begin
            result = '0;
            result[0] = $signed(opA) < $signed(opB);
         end
         exPkg::aluSltu: begin
            result = '0;
            result[0] = opA < opB;
         end
         default:        result = '0;          // Unused codes
      endcase
   end

   // Signed overflow from operand signs against the result sign
   assign addOvf = (opA[exPkg::xlen-1] == opB[exPkg::xlen-1])
                   && (result[exPkg::xlen-1] != opA[exPkg::xlen-1]);
   assign subOvf = (opA[exPkg::xlen-1] != opB[exPkg::xlen-1])
                   && (result[exPkg::xlen-1] != opA[exPkg::xlen-1]);

   always_comb begin
      flags.negative = result[exPkg::xlen-1];
      flags.zero     = (result == '0);
      // For SUB the top bit of the wide difference is the unsigned borrow
      flags.carry    = (isAdd || isSub) && sum[exPkg::xlen];
      flags.overflow = (isAdd && addOvf) || (isSub && subOvf);
   end

   // Equal operands leave nothing in a difference or an XOR
   always_comb begin
      zeroFlagCheck: assert final (!(isSub || aluOp == exPkg::aluXor)
                                   || (flags.zero == (opA == opB)))
         else $error("alu: zero flag disagrees with the operands");
   end

endmodule

`default_nettype wire

// ==== logic/operandFwd.sv ====
`timescale 1ns/1ps
`default_nettype none

module operandFwd (
   input  exPkg::idExT              exInstr,
   input  exPkg::exMemT             exMemHeld,
   input  logic                     exMemValid,
   input  exPkg::wbFwdT             wbFwd,
   output logic [exPkg::xlen-1:0]   opA,
   output logic [exPkg::xlen-1:0]   opB,
   output exPkg::aluOpE             aluOp
);

   exPkg::fwdSrcE srcA;
   exPkg::fwdSrcE srcB;
   logic [exPkg::xlen-1:0] fwdB;              // Operand B before immediate select

   // EX/MEM is the younger result, so it wins over writeback
   function automatic exPkg::fwdSrcE classify(input logic [exPkg::regAddrW-1:0] rs);
      logic exMemHit;
      logic wbHit;
      exMemHit = exMemValid && exMemHeld.regWrite && (exMemHeld.rd != '0)
                 && (exMemHeld.rd == rs);
      wbHit    = wbFwd.regWrite && (wbFwd.rd != '0) && (wbFwd.rd == rs);
      if (exMemHit) begin
         return exPkg::fromExMem;
      end else if (wbHit) begin
         return exPkg::fromWb;
      end
      return exPkg::fromReg;
   endfunction

   // Hazard state also follows the EX/MEM and writeback inputs
   always_comb begin
      srcA = classify(exInstr.rs1);
      srcB = classify(exInstr.rs2);
   end

   always_comb begin
      case (srcA)
         exPkg::fromExMem: opA = exMemHeld.result;
         exPkg::fromWb:    opA = wbFwd.result;
         default:          opA = exInstr.rs1Val;
      endcase
   end

   always_comb begin
      case (srcB)
         exPkg::fromExMem: fwdB = exMemHeld.result;
         exPkg::fromWb:    fwdB = wbFwd.result;
         default:          fwdB = exInstr.rs2Val;
      endcase
   end

   // Immediate forms take B from the instruction itself
   assign opB = exInstr.useImm ? exInstr.imm : fwdB;

   assign aluOp = exInstr.aluOp;

endmodule

`default_nettype wire

// ==== logic/idExReg.sv ====
`timescale 1ns/1ps
`default_nettype none

module idExReg (
   input  logic        clk,
   input  logic        rst,
   input  logic        inValid,
   output logic        inReady,
   input  exPkg::idExT inInstr,
   input  logic        exAdvance,
   output logic        exValid,
   output exPkg::idExT exInstr
);

   logic load;

   // Room when empty or when the current item moves on
   assign inReady = !exValid || exAdvance;
   assign load    = inValid && inReady;

   always_ff @(posedge clk) begin
      if (rst) begin
         exValid <= 1'b0;
      end else if (inReady) begin
         exValid <= inValid;                  // Drains to empty if nothing new
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         exInstr <= inInstr;
      end
   end

   // A stalled instruction keeps its fields and its valid bit
   property holdWhileStalled;
      @(posedge clk) disable iff (rst)
         exValid && !exAdvance |=> exValid && $stable(exInstr);
   endproperty

   stallHold: assert property (holdWhileStalled)
      else $error("idExReg: execute contents changed while stalled");

endmodule

`default_nettype wire

// ==== logic/exPkg.sv ====
`default_nettype none

package exPkg;

   localparam int xlen = 32;                  // Data path width
   localparam int regAddrW = 5;               // Register number width
   localparam int aluOpW = 4;

   // ALU opcode values follow the existing ALU control encoding
   typedef enum logic [aluOpW-1:0] {
      aluAnd  = 4'b0000,
      aluOr   = 4'b0001,
      aluAdd  = 4'b0010,
      aluXor  = 4'b0011,
      aluSll  = 4'b0100,
      aluSrl  = 4'b0101,
      aluSub  = 4'b0110,
      aluSra  = 4'b0111,
      aluSlt  = 4'b1000,
      aluSltu = 4'b1001
   } aluOpE;

   // Where an operand value comes from
   typedef enum logic [1:0] {
      fromReg   = 2'b00,                      // Register file value
      fromExMem = 2'b01,                      // Result held in EX/MEM
      fromWb    = 2'b10                       // Result in writeback
   } fwdSrcE;

   typedef struct packed {
      logic negative;
      logic zero;
      logic carry;                            // ADD and SUB only
      logic overflow;                         // ADD and SUB only
   } aluFlagsT;

   // Decoded instruction entering execute
   typedef struct packed {
      logic [regAddrW-1:0] rs1;
      logic [regAddrW-1:0] rs2;
      logic [regAddrW-1:0] rd;
      logic [xlen-1:0]     rs1Val;            // From register file
      logic [xlen-1:0]     rs2Val;
      logic [xlen-1:0]     imm;               // Sign extended by decode
      logic                useImm;            // Immediate replaces operand B
      aluOpE               aluOp;
      logic                regWrite;
   } idExT;

   // Result leaving execute
   typedef struct packed {
      logic [regAddrW-1:0] rd;
      logic                regWrite;
      logic [xlen-1:0]     result;
      aluFlagsT            flags;
   } exMemT;

   // Value being written back this cycle
   typedef struct packed {
      logic                regWrite;
      logic [regAddrW-1:0] rd;
      logic [xlen-1:0]     result;
   } wbFwdT;

endpackage

`default_nettype wire
